// ==== husky_reg_pkg.sv ====
package husky_reg_pkg;

   // Bus and register byte widths
   localparam int DATA_W = 8;
   localparam int ADDR_W = 8;

   // Byte length of the multi-byte registers
   localparam int MULTI_BYTES = 4;

   // Firmware identity read back least significant byte first
   localparam logic [8*MULTI_BYTES-1:0] FW_ID = 32'h4855_5331;

   // Register map as seen from the USB bus
   typedef enum logic [ADDR_W-1:0] {
      REG_PIN_CTRL = 8'h10,   // One byte of target pin control
      REG_SCRATCH  = 8'h11,   // MULTI_BYTES of read/write scratch
      REG_FW_ID    = 8'h12    // Read-only identity
   } reg_addr_e;

endpackage

// ==== husky_io_pkg.sv ====
package husky_io_pkg;

   // Bit positions inside the pin-control byte
   localparam int PIN_AVRPROG   = 0;   // SPI passthrough that holds nRST low
   localparam int PIN_NRST_EN   = 1;
   localparam int PIN_NRST      = 2;
   localparam int PIN_PDID_EN   = 3;
   localparam int PIN_PDID      = 4;
   localparam int PIN_PDIC_EN   = 5;
   localparam int PIN_PDIC      = 6;
   localparam int PIN_POWER_OFF = 7;   // Set means target unpowered

   // Target starts unpowered with every pin floating
   localparam logic [7:0] PIN_CTRL_RESET = 8'(1 << PIN_POWER_OFF);

   // How the target reset pin is driven
   typedef enum logic [1:0] {
      NRST_FLOAT,
      NRST_AVRPROG_LOW,
      NRST_DRIVE
   } nrst_mode_e;

endpackage

// ==== usb_bus_frontend.sv ====
`timescale 1ns/1ps

module usb_bus_frontend #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                             clk_usb_i,
   input  logic                             rst_n_i,
   input  logic [husky_reg_pkg::ADDR_W-1:0] usb_addr_i,
   input  logic [husky_reg_pkg::DATA_W-1:0] usb_data_i,
   input  logic                             usb_rdn_i,
   input  logic                             usb_wrn_i,
   input  logic                             usb_cen_i,
   input  logic                             usb_alen_i,
   input  logic [husky_reg_pkg::DATA_W-1:0] reg_rdata_i,
   output logic [husky_reg_pkg::DATA_W-1:0] usb_data_o,
   output logic                             usb_data_oe_o,
   output logic [husky_reg_pkg::ADDR_W-1:0] reg_address_o,
   output logic [pBYTECNT_SIZE-1:0]         reg_bytecnt_o,
   output logic [husky_reg_pkg::DATA_W-1:0] reg_wdata_o,
   output logic                             reg_write_o,
   output logic                             reg_read_o
);

   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_WRITE,
      BUS_READ
   } bus_phase_e;

   bus_phase_e                       phase_q;
   logic                             rdn_q;
   logic                             rdn_d;
   logic                             wrn_q;
   logic                             wrn_d;
   logic                             cen_q;
   logic                             alen_q;
   logic [husky_reg_pkg::ADDR_W-1:0] addr_q;
   logic [husky_reg_pkg::DATA_W-1:0] data_q;
   logic                             rd_fall;
   logic                             rd_rise;
   logic                             wr_fall;
   logic                             wr_rise;
   logic                             addr_phase;

   // Strobe sample and delay stages for edge detection
   always_ff @(posedge clk_usb_i) begin
      if (!rst_n_i) begin
         rdn_q  <= 1'b1;
         rdn_d  <= 1'b1;
         wrn_q  <= 1'b1;
         wrn_d  <= 1'b1;
         cen_q  <= 1'b1;
         alen_q <= 1'b1;
      end else begin
         rdn_q  <= usb_rdn_i;
         rdn_d  <= rdn_q;
         wrn_q  <= usb_wrn_i;
         wrn_d  <= wrn_q;
         cen_q  <= usb_cen_i;
         alen_q <= usb_alen_i;
      end
   end

   // Address and data sampled alongside the strobes
   always_ff @(posedge clk_usb_i) begin
      addr_q <= usb_addr_i;
      data_q <= usb_data_i;
   end

   assign rd_fall    = rdn_d & ~rdn_q;
   assign rd_rise    = ~rdn_d & rdn_q;
   assign wr_fall    = wrn_d & ~wrn_q;
   assign wr_rise    = ~wrn_d & wrn_q;
   assign addr_phase = ~cen_q & ~alen_q;

   always_ff @(posedge clk_usb_i) begin
      if (!rst_n_i) begin
         phase_q       <= BUS_IDLE;
         reg_write_o   <= 1'b0;
         reg_read_o    <= 1'b0;
         reg_bytecnt_o <= '0;
         usb_data_oe_o <= 1'b0;
      end else begin
         reg_write_o <= 1'b0;   // Single-cycle pulses
         reg_read_o  <= 1'b0;
         case (phase_q)
            BUS_IDLE: begin
               if (!cen_q && wr_fall) begin
                  phase_q     <= BUS_WRITE;
                  reg_write_o <= 1'b1;
               end else if (!cen_q && rd_fall) begin
                  phase_q    <= BUS_READ;
                  reg_read_o <= 1'b1;
               end
            end
            BUS_WRITE: begin
               if (wr_rise) begin
                  phase_q       <= BUS_IDLE;
                  reg_bytecnt_o <= reg_bytecnt_o + 1'b1;
               end
            end
            BUS_READ: begin
               if (rd_rise) begin
                  phase_q       <= BUS_IDLE;
                  reg_bytecnt_o <= reg_bytecnt_o + 1'b1;
                  usb_data_oe_o <= 1'b0;   // Release bus after RDn
               end
            end
            default: phase_q <= BUS_IDLE;
         endcase
         if (reg_read_o)
            usb_data_oe_o <= 1'b1;
         // New address restarts the byte sequence
         if (addr_phase)
            reg_bytecnt_o <= '0;
      end
   end

   always_ff @(posedge clk_usb_i) begin
      if (addr_phase)
         reg_address_o <= addr_q;
      if (phase_q == BUS_IDLE && !cen_q && wr_fall)
         reg_wdata_o <= data_q;
      if (reg_read_o)
         usb_data_o <= reg_rdata_i;   // Held until the next read
   end

endmodule

// ==== husky_reg_bank.sv ====
`timescale 1ns/1ps

module husky_reg_bank #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                             clk_usb_i,
   input  logic                             rst_n_i,
   input  logic [husky_reg_pkg::ADDR_W-1:0] reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0]         reg_bytecnt_i,
   input  logic [husky_reg_pkg::DATA_W-1:0] reg_wdata_i,
   input  logic                             reg_write_i,
   input  logic                             reg_read_i,
   output logic [husky_reg_pkg::DATA_W-1:0] reg_rdata_o,
   output logic [husky_reg_pkg::DATA_W-1:0] pin_ctrl_o
);

   localparam int SEL_W = $clog2(husky_reg_pkg::MULTI_BYTES);
   localparam int DW    = husky_reg_pkg::DATA_W;

   husky_reg_pkg::reg_addr_e addr_sel;
   logic [SEL_W-1:0]         byte_sel;
   logic                     byte_in_range;
   logic                     byte_first;
   logic [DW-1:0]            scratch_q [husky_reg_pkg::MULTI_BYTES];
   logic [DW-1:0]            pin_ctrl_q;

   assign addr_sel      = husky_reg_pkg::reg_addr_e'(reg_address_i);
   assign byte_sel      = reg_bytecnt_i[SEL_W-1:0];
   assign byte_in_range = reg_bytecnt_i < pBYTECNT_SIZE'(husky_reg_pkg::MULTI_BYTES);
   assign byte_first    = reg_bytecnt_i == '0;

   // Pin control powers up with the target off
   always_ff @(posedge clk_usb_i) begin
      if (!rst_n_i) begin
         pin_ctrl_q <= husky_io_pkg::PIN_CTRL_RESET;
      end else if (reg_write_i && addr_sel == husky_reg_pkg::REG_PIN_CTRL && byte_first) begin
         pin_ctrl_q <= reg_wdata_i;
      end
   end

   always_ff @(posedge clk_usb_i) begin
      if (reg_write_i && addr_sel == husky_reg_pkg::REG_SCRATCH && byte_in_range)
         scratch_q[byte_sel] <= reg_wdata_i;
   end

   // Read mux returns zero for anything not mapped
   always_comb begin
      reg_rdata_o = '0;
      if (reg_read_i) begin
         case (addr_sel)
            husky_reg_pkg::REG_PIN_CTRL: begin
               if (byte_first)
                  reg_rdata_o = pin_ctrl_q;
            end
            husky_reg_pkg::REG_SCRATCH: begin
               if (byte_in_range)
                  reg_rdata_o = scratch_q[byte_sel];
            end
            husky_reg_pkg::REG_FW_ID: begin
               if (byte_in_range)
                  reg_rdata_o = husky_reg_pkg::FW_ID[byte_sel*DW +: DW];   // LSB first
            end
            default: reg_rdata_o = '0;
         endcase
      end
   end

   assign pin_ctrl_o = pin_ctrl_q;

endmodule

// ==== target_io_mux.sv ====
`timescale 1ns/1ps

module target_io_mux (
   input  logic [7:0] pin_ctrl_i,
   input  logic       sam_mosi_i,
   input  logic       sam_spck_i,
   input  logic       target_miso_i,
   output logic       target_nrst_o,
   output logic       target_nrst_oe_o,
   output logic       target_pdid_o,
   output logic       target_pdid_oe_o,
   output logic       target_pdic_o,
   output logic       target_pdic_oe_o,
   output logic       target_mosi_o,
   output logic       target_sck_o,
   output logic       target_spi_oe_o,
   output logic       sam_miso_o,
   output logic       sam_miso_oe_o,
   output logic       target_poweron_o
);

   husky_io_pkg::nrst_mode_e nrst_mode;
   logic                     power_off;
   logic                     avrprog;

   assign power_off = pin_ctrl_i[husky_io_pkg::PIN_POWER_OFF];
   assign avrprog   = pin_ctrl_i[husky_io_pkg::PIN_AVRPROG];

   // AVR programming wins over the plain nRST drive
   always_comb begin
      if (avrprog)
         nrst_mode = husky_io_pkg::NRST_AVRPROG_LOW;
      else if (pin_ctrl_i[husky_io_pkg::PIN_NRST_EN])
         nrst_mode = husky_io_pkg::NRST_DRIVE;
      else
         nrst_mode = husky_io_pkg::NRST_FLOAT;
   end

   assign target_nrst_oe_o = ~power_off && (nrst_mode != husky_io_pkg::NRST_FLOAT);
   assign target_nrst_o    = (nrst_mode == husky_io_pkg::NRST_DRIVE) &&
                             pin_ctrl_i[husky_io_pkg::PIN_NRST];

   assign target_pdid_oe_o = ~power_off & pin_ctrl_i[husky_io_pkg::PIN_PDID_EN];
   assign target_pdid_o    = pin_ctrl_i[husky_io_pkg::PIN_PDID];
   assign target_pdic_oe_o = ~power_off & pin_ctrl_i[husky_io_pkg::PIN_PDIC_EN];
   assign target_pdic_o    = pin_ctrl_i[husky_io_pkg::PIN_PDIC];

   // SPI passthrough from the microcontroller
   assign target_mosi_o   = sam_mosi_i;
   assign target_sck_o    = sam_spck_i;
   assign target_spi_oe_o = ~power_off & avrprog;

   assign sam_miso_o    = target_miso_i;
   assign sam_miso_oe_o = avrprog;   // Not gated by power

   assign target_poweron_o = ~power_off;

endmodule

// ==== status_led.sv ====
`timescale 1ns/1ps

module status_led #(
   parameter int pFLASH_BITS = 4
) (
   input  logic clk_usb_i,
   input  logic rst_n_i,
   input  logic error_i,
   input  logic pll_status_i,
   input  logic glitch_led_i,
   output logic led_adc_o,
   output logic led_glitch_o
);

   logic [pFLASH_BITS:0] flash_cnt_q;
   logic                 flash_pattern;

   // Top bit toggles every 2**pFLASH_BITS cycles
   always_ff @(posedge clk_usb_i) begin
      if (!rst_n_i)
         flash_cnt_q <= '0;
      else
         flash_cnt_q <= flash_cnt_q + 1'b1;
   end

   assign flash_pattern = flash_cnt_q[pFLASH_BITS];

   // Both red LEDs flash on error
   always_ff @(posedge clk_usb_i) begin
      if (!rst_n_i) begin
         led_adc_o    <= 1'b0;
         led_glitch_o <= 1'b0;
      end else if (error_i) begin
         led_adc_o    <= flash_pattern;
         led_glitch_o <= flash_pattern;
      end else begin
         led_adc_o    <= ~pll_status_i;   // Lit when PLL unlocked
         led_glitch_o <= glitch_led_i;
      end
   end

endmodule

// ==== husky_top.sv ====
`timescale 1ns/1ps

module husky_top #(
   parameter int pBYTECNT_SIZE = 7,
   parameter int pFLASH_BITS   = 4
) (
   input  logic                             clk_usb_i,
   input  logic                             rst_n_i,
   input  logic [husky_reg_pkg::ADDR_W-1:0] usb_addr_i,
   input  logic [husky_reg_pkg::DATA_W-1:0] usb_data_i,
   output logic [husky_reg_pkg::DATA_W-1:0] usb_data_o,
   output logic                             usb_data_oe_o,
   input  logic                             usb_rdn_i,
   input  logic                             usb_wrn_i,
   input  logic                             usb_cen_i,
   input  logic                             usb_alen_i,
   input  logic                             error_i,
   input  logic                             pll_status_i,
   input  logic                             glitch_led_i,
   input  logic                             sam_mosi_i,
   input  logic                             sam_spck_i,
   input  logic                             target_miso_i,
   output logic                             led_adc_o,
   output logic                             led_glitch_o,
   output logic                             target_nrst_o,
   output logic                             target_nrst_oe_o,
   output logic                             target_pdid_o,
   output logic                             target_pdid_oe_o,
   output logic                             target_pdic_o,
   output logic                             target_pdic_oe_o,
   output logic                             target_mosi_o,
   output logic                             target_sck_o,
   output logic                             target_spi_oe_o,
   output logic                             sam_miso_o,
   output logic                             sam_miso_oe_o,
   output logic                             target_poweron_o
);

   logic [husky_reg_pkg::ADDR_W-1:0] reg_address;
   logic [pBYTECNT_SIZE-1:0]         reg_bytecnt;
   logic [husky_reg_pkg::DATA_W-1:0] reg_wdata;
   logic [husky_reg_pkg::DATA_W-1:0] reg_rdata;
   logic                             reg_write;
   logic                             reg_read;
   logic [husky_reg_pkg::DATA_W-1:0] pin_ctrl;

   usb_bus_frontend #(
      .pBYTECNT_SIZE (pBYTECNT_SIZE)
   ) u_usb_bus_frontend (
      .clk_usb_i     (clk_usb_i),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_address_o (reg_address),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read)
   );

   husky_reg_bank #(
      .pBYTECNT_SIZE (pBYTECNT_SIZE)
   ) u_husky_reg_bank (
      .clk_usb_i     (clk_usb_i),
      .rst_n_i       (rst_n_i),
      .reg_address_i (reg_address),
      .reg_bytecnt_i (reg_bytecnt),
      .reg_wdata_i   (reg_wdata),
      .reg_write_i   (reg_write),
      .reg_read_i    (reg_read),
      .reg_rdata_o   (reg_rdata),
      .pin_ctrl_o    (pin_ctrl)
   );

   // Target-facing pins
   target_io_mux u_target_io_mux (
      .pin_ctrl_i       (pin_ctrl),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdid_oe_o (target_pdid_oe_o),
      .target_pdic_o    (target_pdic_o),
      .target_pdic_oe_o (target_pdic_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_sck_o     (target_sck_o),
      .target_spi_oe_o  (target_spi_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o),
      .target_poweron_o (target_poweron_o)
   );

   status_led #(
      .pFLASH_BITS (pFLASH_BITS)
   ) u_status_led (
      .clk_usb_i    (clk_usb_i),
      .rst_n_i      (rst_n_i),
      .error_i      (error_i),
      .pll_status_i (pll_status_i),
      .glitch_led_i (glitch_led_i),
      .led_adc_o    (led_adc_o),
      .led_glitch_o (led_glitch_o)
   );

endmodule

// ==== husky_checker.sv ====
`timescale 1ns/1ps

module husky_checker #(
   parameter int pFLASH_BITS = 4
) (
   input  logic                             clk_usb_i,
   input  logic                             rst_n_i,
   input  logic [husky_reg_pkg::ADDR_W-1:0] usb_addr_i,
   input  logic [husky_reg_pkg::DATA_W-1:0] usb_data_i,
   input  logic                             usb_rdn_i,
   input  logic                             usb_wrn_i,
   input  logic                             usb_cen_i,
   input  logic                             usb_alen_i,
   input  logic                             error_i,
   input  logic                             pll_status_i,
   input  logic                             glitch_led_i,
   input  logic                             sam_mosi_i,
   input  logic                             sam_spck_i,
   input  logic                             target_miso_i,
   input  logic [husky_reg_pkg::DATA_W-1:0] dut_rdata_i,
   input  logic                             dut_rdata_oe_i,
   input  logic                             led_adc_i,
   input  logic                             led_glitch_i,
   input  logic                             nrst_i,
   input  logic                             nrst_oe_i,
   input  logic                             pdid_i,
   input  logic                             pdid_oe_i,
   input  logic                             pdic_i,
   input  logic                             pdic_oe_i,
   input  logic                             mosi_i,
   input  logic                             sck_i,
   input  logic                             spi_oe_i,
   input  logic                             miso_i,
   input  logic                             miso_oe_i,
   input  logic                             poweron_i,
   output int                               errors_o
);

   localparam int IDX_W       = $clog2(husky_reg_pkg::MULTI_BYTES);
   localparam int FLASH_LIMIT = 2 * (1 << pFLASH_BITS);

   logic [7:0]  scratch_m [husky_reg_pkg::MULTI_BYTES];
   logic [7:0]  pin_ctrl_m;
   logic [7:0]  addr_m;
   int          bytecnt_m;
   logic        rdn_s;
   logic        wrn_s;
   logic        err_s;
   logic        pll_s;
   logic        glitch_s;
   logic        led_prev;
   logic        was_reset;
   int          pin_wait;
   int          flash_age;
   int          err_cnt = 0;
   logic [11:0] pins_dut;

   assign errors_o = err_cnt;
   assign pins_dut = {nrst_i, nrst_oe_i, pdid_i, pdid_oe_i, pdic_i, pdic_oe_i,
                      mosi_i, sck_i, spi_oe_i, miso_i, miso_oe_i, poweron_i};

   task automatic report_fail(input string msg);
      $display("Fail at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   // Register map as seen from the bus
   function automatic logic [7:0] ref_read(input logic [7:0] addr, input int cnt);
      ref_read = 8'h00;
      if (addr == husky_reg_pkg::REG_PIN_CTRL && cnt == 0)
         ref_read = pin_ctrl_m;
      else if (addr == husky_reg_pkg::REG_SCRATCH && cnt < husky_reg_pkg::MULTI_BYTES)
         ref_read = scratch_m[IDX_W'(cnt)];
      else if (addr == husky_reg_pkg::REG_FW_ID && cnt < husky_reg_pkg::MULTI_BYTES)
         ref_read = 8'(husky_reg_pkg::FW_ID >> (8 * cnt));   // LSB first
   endfunction

   // Same bit order as pins_dut
   function automatic logic [11:0] ref_pins(input logic [7:0] pc, input logic mosi,
                                            input logic sck, input logic miso);
      husky_io_pkg::nrst_mode_e mode;
      logic                     on;
      on = !pc[husky_io_pkg::PIN_POWER_OFF];
      if (pc[husky_io_pkg::PIN_AVRPROG])
         mode = husky_io_pkg::NRST_AVRPROG_LOW;
      else if (pc[husky_io_pkg::PIN_NRST_EN])
         mode = husky_io_pkg::NRST_DRIVE;
      else
         mode = husky_io_pkg::NRST_FLOAT;
      ref_pins = {mode == husky_io_pkg::NRST_DRIVE && pc[husky_io_pkg::PIN_NRST],
                  on && mode != husky_io_pkg::NRST_FLOAT,
                  pc[husky_io_pkg::PIN_PDID], on && pc[husky_io_pkg::PIN_PDID_EN],
                  pc[husky_io_pkg::PIN_PDIC], on && pc[husky_io_pkg::PIN_PDIC_EN],
                  mosi, sck, on && pc[husky_io_pkg::PIN_AVRPROG],
                  miso, pc[husky_io_pkg::PIN_AVRPROG], on};
   endfunction

   always @(posedge clk_usb_i) begin
      if (!rst_n_i) begin
         was_reset  = 1'b1;
         rdn_s      = 1'b1;
         wrn_s      = 1'b1;
         bytecnt_m  = 0;
         pin_ctrl_m = husky_io_pkg::PIN_CTRL_RESET;
         pin_wait   = 0;
         flash_age  = 0;
      end else begin
         if (was_reset) begin
            if (dut_rdata_oe_i || nrst_oe_i || pdid_oe_i || pdic_oe_i || spi_oe_i || poweron_i)
               report_fail("bus enable, target enable or power on after reset");
            was_reset = 1'b0;
         end else if (!err_s) begin
            flash_age = 0;
            if (led_adc_i !== ~pll_s || led_glitch_i !== glitch_s)
               report_fail($sformatf("LEDs %b%b with pll %b glitch %b",
                                     led_adc_i, led_glitch_i, pll_s, glitch_s));
         end else begin
            if (led_adc_i !== led_glitch_i)
               report_fail("LEDs differ while error is set");
            flash_age = (led_adc_i !== led_prev) ? 0 : flash_age + 1;
            if (flash_age > FLASH_LIMIT) begin
               report_fail("error flash stopped toggling");
               flash_age = 0;
            end
         end
         led_prev = led_adc_i;

         // Pins settle 2 cycles after the write pulse
         if (pin_wait != 0) begin
            pin_wait--;
            if (pin_wait == 0 &&
                pins_dut !== ref_pins(pin_ctrl_m, sam_mosi_i, sam_spck_i, target_miso_i))
               report_fail($sformatf("pins %b for control %02h", pins_dut, pin_ctrl_m));
         end

         if (!usb_cen_i && !usb_alen_i) begin
            addr_m    = usb_addr_i;
            bytecnt_m = 0;
         end
         if (!usb_cen_i && wrn_s && !usb_wrn_i) begin
            if (addr_m == husky_reg_pkg::REG_PIN_CTRL && bytecnt_m == 0)
               pin_ctrl_m = usb_data_i;
            else if (addr_m == husky_reg_pkg::REG_SCRATCH &&
                     bytecnt_m < husky_reg_pkg::MULTI_BYTES)
               scratch_m[IDX_W'(bytecnt_m)] = usb_data_i;
            pin_wait = 3;
         end
         if (!wrn_s && usb_wrn_i)
            bytecnt_m++;
         if (!rdn_s && usb_rdn_i) begin
            if (!dut_rdata_oe_i || dut_rdata_i !== ref_read(addr_m, bytecnt_m))
               report_fail($sformatf("read %02h byte %0d got %02h oe %b expected %02h",
                                     addr_m, bytecnt_m, dut_rdata_i, dut_rdata_oe_i,
                                     ref_read(addr_m, bytecnt_m)));
            bytecnt_m++;
         end
      end
      rdn_s    = usb_rdn_i;
      wrn_s    = usb_wrn_i;
      err_s    = error_i;
      pll_s    = pll_status_i;
      glitch_s = glitch_led_i;
   end

endmodule

// ==== tb_husky_top.sv ====
`timescale 1ns/1ps

module tb_husky_top;

   localparam int BYTECNT_SIZE = 7;
   localparam int FLASH_BITS   = 4;
   localparam int WAIT_LIMIT   = 12;

   logic       clk_usb_i;
   logic       rst_n_i;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_data_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic       usb_rdn_i;
   logic       usb_wrn_i;
   logic       usb_cen_i;
   logic       usb_alen_i;
   logic       error_i;
   logic       pll_status_i;
   logic       glitch_led_i;
   logic       sam_mosi_i;
   logic       sam_spck_i;
   logic       target_miso_i;
   logic       led_adc_o;
   logic       led_glitch_o;
   logic       target_nrst_o;
   logic       target_nrst_oe_o;
   logic       target_pdid_o;
   logic       target_pdid_oe_o;
   logic       target_pdic_o;
   logic       target_pdic_oe_o;
   logic       target_mosi_o;
   logic       target_sck_o;
   logic       target_spi_oe_o;
   logic       sam_miso_o;
   logic       sam_miso_oe_o;
   logic       target_poweron_o;
   int         seed;
   int         tb_errors;
   int         chk_errors;
   // Power-off with AVR prog, AVR prog alone, AVR prog over nRST, nRST drive, PDI
   logic [7:0] corner_pins [8] = '{8'h81, 8'h01, 8'h07, 8'h06, 8'h02, 8'h78, 8'hf9, 8'h00};

   husky_top #(
      .pBYTECNT_SIZE (BYTECNT_SIZE),
      .pFLASH_BITS   (FLASH_BITS)
   ) uut (.*);

   husky_checker #(
      .pFLASH_BITS (FLASH_BITS)
   ) husky_checker (
      .*,
      .dut_rdata_i    (usb_data_o),
      .dut_rdata_oe_i (usb_data_oe_o),
      .led_adc_i      (led_adc_o),
      .led_glitch_i   (led_glitch_o),
      .nrst_i         (target_nrst_o),
      .nrst_oe_i      (target_nrst_oe_o),
      .pdid_i         (target_pdid_o),
      .pdid_oe_i      (target_pdid_oe_o),
      .pdic_i         (target_pdic_o),
      .pdic_oe_i      (target_pdic_oe_o),
      .mosi_i         (target_mosi_o),
      .sck_i          (target_sck_o),
      .spi_oe_i       (target_spi_oe_o),
      .miso_i         (sam_miso_o),
      .miso_oe_i      (sam_miso_oe_o),
      .poweron_i      (target_poweron_o),
      .errors_o       (chk_errors)
   );

   always #50 clk_usb_i = ~clk_usb_i;

   task automatic end_run();
      $display("Checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   endtask

   task automatic wait_data_oe(input logic level);
      int n;
      n = 0;
      do begin
         @(posedge clk_usb_i);
         n++;
      end while (usb_data_oe_o !== level && n < WAIT_LIMIT);
      if (usb_data_oe_o !== level) begin
         $display("Timeout: usb_data_oe_o did not go to %0b by %0t", level, $time);
         tb_errors++;
         end_run();
      end
   endtask

   // ALEn low for 2 cycles latches the address
   task automatic set_address(input logic [7:0] addr);
      @(posedge clk_usb_i);
      usb_cen_i  <= 1'b0;
      usb_alen_i <= 1'b0;
      usb_addr_i <= addr;
      repeat (2) @(posedge clk_usb_i);
      usb_alen_i <= 1'b1;
   endtask

   task automatic bus_write(input logic [7:0] data);
      @(posedge clk_usb_i);
      usb_data_i <= data;
      usb_wrn_i  <= 1'b0;
      repeat (4) @(posedge clk_usb_i);
      usb_wrn_i <= 1'b1;
      @(posedge clk_usb_i);
   endtask

   task automatic bus_read();
      @(posedge clk_usb_i);
      usb_rdn_i <= 1'b0;
      wait_data_oe(1'b1);
      usb_rdn_i <= 1'b1;   // Data is on the bus by now
      wait_data_oe(1'b0);
   endtask

   task automatic pin_case(input logic [7:0] value);
      @(posedge clk_usb_i);
      sam_mosi_i    <= 1'($random(seed));
      sam_spck_i    <= 1'($random(seed));
      target_miso_i <= 1'($random(seed));
      set_address(husky_reg_pkg::REG_PIN_CTRL);
      bus_write(value);
      set_address(husky_reg_pkg::REG_PIN_CTRL);
      bus_read();
   endtask

   initial begin
      seed          = 49;
      tb_errors     = 0;
      clk_usb_i     = 1'b0;
      rst_n_i       = 1'b0;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_cen_i     = 1'b1;
      usb_alen_i    = 1'b1;
      error_i       = 1'b0;
      pll_status_i  = 1'b1;
      glitch_led_i  = 1'b0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      repeat (2) @(posedge clk_usb_i);
      rst_n_i <= 1'b1;
      repeat (2) @(posedge clk_usb_i);

      // Fill scratch and read back past its end
      set_address(husky_reg_pkg::REG_SCRATCH);
      repeat (husky_reg_pkg::MULTI_BYTES) bus_write(8'($random(seed)));
      set_address(husky_reg_pkg::REG_SCRATCH);
      repeat (husky_reg_pkg::MULTI_BYTES + 2) bus_read();

      set_address(husky_reg_pkg::REG_FW_ID);
      repeat (husky_reg_pkg::MULTI_BYTES + 1) bus_read();
      set_address(8'h3c);   // Unmapped
      repeat (2) bus_read();

      foreach (corner_pins[i])
         pin_case(corner_pins[i]);
      repeat (24) pin_case(8'($random(seed)));

      // LEDs track PLL and glitch inputs and flash on error
      repeat (20) begin
         @(posedge clk_usb_i);
         pll_status_i <= 1'($random(seed));
         glitch_led_i <= 1'($random(seed));
      end
      error_i <= 1'b1;
      repeat (4 << FLASH_BITS) @(posedge clk_usb_i);
      error_i <= 1'b0;
      repeat (4) @(posedge clk_usb_i);
      end_run();
   end

endmodule

// ==== sources.f ====
husky_reg_pkg.sv
husky_io_pkg.sv
usb_bus_frontend.sv
husky_reg_bank.sv
target_io_mux.sv
status_led.sv
husky_top.sv
husky_checker.sv
tb_husky_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module tb_husky_top -o tb_husky_top \
   && ./obj_dir/tb_husky_top | tee /dev/stderr | grep -x "No errors" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
